//--- Bender.yml
package:
  name: lite_subsystem

sources:
  - verilog/lite_bus_pkg.sv
  - verilog/rr_arbiter.sv
  - verilog/lite_demux.sv
  - verilog/lite_reg_target.sv
  - verilog/lite_subsystem.sv
  - target: test
    files:
      - verification/lite_subsystem_sva.sv
      - verification/lite_subsystem_tb.sv

//--- lite_subsystem.f
verilog/lite_bus_pkg.sv
verilog/rr_arbiter.sv
verilog/lite_demux.sv
verilog/lite_reg_target.sv
verilog/lite_subsystem.sv
verification/lite_subsystem_sva.sv
verification/lite_subsystem_tb.sv

//--- verification/lite_stim.txt
# op id addr data strb exp, hex fields; W write, R read, P pipelined read
# W lines ignore exp, R and P lines ignore data and strb
R 0 00 00000000 0 00000000
R 1 40 00000000 0 00000000
R 2 80 00000000 0 00000000
R 3 fc 00000000 0 00000000
W 1 04 a5a50001 f 00000000
W 2 44 a5a50002 f 00000000
W 3 84 a5a50003 f 00000000
W 0 c4 a5a50004 f 00000000
R 0 04 00000000 0 a5a50001
R 1 44 00000000 0 a5a50002
R 2 84 00000000 0 a5a50003
R 3 c4 00000000 0 a5a50004
W 2 88 11223344 f 00000000
W 3 88 aabbccdd 5 00000000
R 1 88 00000000 0 11bb33dd
W 0 88 55667788 a 00000000
R 2 88 00000000 0 55bb77dd
P 0 c4 00000000 0 a5a50004
P 1 84 00000000 0 a5a50003
P 2 44 00000000 0 a5a50002
P 3 04 00000000 0 a5a50001
W 1 3c deadbeef f 00000000
W 2 7c 0badf00d f 00000000
W 3 bc 12345678 3 00000000
W 0 fc cafe0000 c 00000000
P 0 3c 00000000 0 deadbeef
P 1 7c 00000000 0 0badf00d
P 2 bc 00000000 0 00005678
P 3 fc 00000000 0 cafe0000

//--- verification/lite_subsystem_sva.sv
// protocol assertions for the NASTI-Lite demultiplexer, bound into lite_demux
`timescale 1ns/1ps
`default_nettype none

module lite_subsystem_sva (
   input logic                                clk,
   input logic                                rstn,
   input logic [lite_bus_pkg::PORTS-1:0]      t_aw_valid,
   input logic [lite_bus_pkg::PORTS-1:0]      t_aw_ready,
   input logic [lite_bus_pkg::PORTS-1:0]      t_w_valid,
   input logic [lite_bus_pkg::PORTS-1:0]      t_w_ready,
   input logic [lite_bus_pkg::PORTS-1:0]      t_ar_valid,
   input logic [lite_bus_pkg::PORTS-1:0]      b_gnt,
   input logic [lite_bus_pkg::PORTS-1:0]      r_gnt,
   input logic                                b_valid,
   input logic                                b_ready,
   input logic [lite_bus_pkg::ID_W-1:0]       b_id,
   input logic [1:0]                          b_resp,
   input logic                                r_valid,
   input logic                                r_ready,
   input logic [lite_bus_pkg::ID_W-1:0]       r_id,
   input logic [lite_bus_pkg::DATA_W-1:0]     r_data,
   input logic [1:0]                          r_resp
);

   logic                             aw_seen;   // a target took AW, its W still due
   logic [lite_bus_pkg::PORTS-1:0]   aw_port;   // target that took that AW

   // write lock as seen from the target handshakes
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         aw_seen <= 1'b0;
         aw_port <= '0;
      end else if (|(t_aw_valid & t_aw_ready)) begin
         aw_seen <= 1'b1;
         aw_port <= t_aw_valid & t_aw_ready;
      end else if (|(t_w_valid & t_w_ready)) begin
         aw_seen <= 1'b0;
      end
   end

   a_req_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(t_aw_valid) && $onehot0(t_w_valid) && $onehot0(t_ar_valid))
      else $error("request valid raised toward more than one target");

   a_gnt_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(b_gnt) && $onehot0(r_gnt))
      else $error("return arbiter grant is not one-hot");

   // a stalled response keeps its valid and payload
   a_b_stable: assert property (@(posedge clk) disable iff (!rstn)
      b_valid && !b_ready |=> b_valid && $stable(b_id) && $stable(b_resp))
      else $error("B channel changed before its handshake");

   a_r_stable: assert property (@(posedge clk) disable iff (!rstn)
      r_valid && !r_ready |=> r_valid && $stable({r_id, r_data, r_resp}))
      else $error("R channel changed before its handshake");

   a_w_locked: assert property (@(posedge clk) disable iff (!rstn)
      (t_w_valid & ~(aw_seen ? aw_port : '0)) == '0)
      else $error("W valid reached a target with no accepted AW");

endmodule

bind lite_demux lite_subsystem_sva u_sva (
   .clk        (clk),
   .rstn       (rstn),
   .t_aw_valid (t_aw_valid),
   .t_aw_ready (t_aw_ready),
   .t_w_valid  (t_w_valid),
   .t_w_ready  (t_w_ready),
   .t_ar_valid (t_ar_valid),
   .b_gnt      (b_gnt),
   .r_gnt      (r_gnt),
   .b_valid    (b_valid),
   .b_ready    (b_ready),
   .b_id       (b_id),
   .b_resp     (b_resp),
   .r_valid    (r_valid),
   .r_ready    (r_ready),
   .r_id       (r_id),
   .r_data     (r_data),
   .r_resp     (r_resp)
);

`default_nettype wire

//--- verification/lite_subsystem_tb.sv
// testbench for lite_subsystem: stimulus file reader, master driver,
// response monitor with random back-pressure, checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module lite_subsystem_tb;

   localparam int         RESET_CYCLES = 8;
   localparam int         LINE_CYCLES  = 200;   // watchdog budget per stimulus line
   localparam             STIM_FILE    = "verification/lite_stim.txt";
   localparam logic [1:0] OKAY         = 2'b00;

   logic                                clk;
   logic                                rstn;
   logic                                aw_valid;
   logic                                aw_ready;
   logic [lite_bus_pkg::ID_W-1:0]       aw_id;
   logic [lite_bus_pkg::ADDR_W-1:0]     aw_addr;
   logic                                w_valid;
   logic                                w_ready;
   logic [lite_bus_pkg::DATA_W-1:0]     w_data;
   logic [3:0]                          w_strb;
   logic                                b_valid;
   logic                                b_ready;
   logic [lite_bus_pkg::ID_W-1:0]       b_id;
   logic [1:0]                          b_resp;
   logic                                ar_valid;
   logic                                ar_ready;
   logic [lite_bus_pkg::ID_W-1:0]       ar_id;
   logic [lite_bus_pkg::ADDR_W-1:0]     ar_addr;
   logic                                r_valid;
   logic                                r_ready;
   logic [lite_bus_pkg::ID_W-1:0]       r_id;
   logic [lite_bus_pkg::DATA_W-1:0]     r_data;
   logic [1:0]                          r_resp;

   logic [7:0]                          op_q[$];     // one entry per stimulus line
   logic [31:0]                         id_q[$];
   logic [31:0]                         addr_q[$];
   logic [31:0]                         data_q[$];
   logic [31:0]                         strb_q[$];
   logic [31:0]                         exp_q[$];
   logic [lite_bus_pkg::ID_W-1:0]       b_id_q[$];   // completed B transfers
   logic [1:0]                          b_resp_q[$];
   logic [lite_bus_pkg::ID_W-1:0]       r_id_q[$];   // completed R transfers
   logic [lite_bus_pkg::DATA_W-1:0]     r_data_q[$];
   logic [1:0]                          r_resp_q[$];
   logic [lite_bus_pkg::DATA_W-1:0]     pend_exp[1 << lite_bus_pkg::ID_W];
   logic                                pend_on[1 << lite_bus_pkg::ID_W];
   int                                  pend_cnt;
   int                                  errors;
   int                                  tests;
   int                                  limit_cycles;
   int                                  fd;
   int                                  nread;
   string                               line;
   logic [7:0]                          f_op;
   logic [31:0]                         f_id, f_addr, f_data, f_strb, f_exp;
   logic [31:0]                         seed;

   lite_subsystem u_dut (.*);

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                  $time, msg, actual, expected);
         errors++;
      end
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic report_test(input string what, input int errs_before);
      tests++;
      $display("test %0d %s: %s", tests, what, (errors == errs_before) ? "ok" : "FAILED");
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // return readies drop on random cycles
   initial begin
      seed    = 32'h1f77;
      b_ready = 1'b0;
      r_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         seed    = lcg_next(seed);
         b_ready = seed[31:30] != 2'b00;   // low about one cycle in four
         r_ready = seed[29:28] != 2'b00;
      end
   end

   // handshakes seen here transfer on the next rising edge
   always @(negedge clk) begin
      if (rstn && b_valid && b_ready) begin
         b_id_q.push_back(b_id);
         b_resp_q.push_back(b_resp);
      end
      if (rstn && r_valid && r_ready) begin
         r_id_q.push_back(r_id);
         r_data_q.push_back(r_data);
         r_resp_q.push_back(r_resp);
      end
   end

   task automatic issue_write(input int n);
      aw_valid = 1'b1;
      aw_id    = id_q[n][lite_bus_pkg::ID_W-1:0];
      aw_addr  = addr_q[n][lite_bus_pkg::ADDR_W-1:0];
      do @(negedge clk); while (!aw_ready);
      @(posedge clk);
      #1;
      aw_valid = 1'b0;
      w_valid  = 1'b1;             // W only after AW has gone
      w_data   = data_q[n];
      w_strb   = strb_q[n][3:0];
      do @(negedge clk); while (!w_ready);
      @(posedge clk);
      #1;
      w_valid = 1'b0;
   endtask

   task automatic issue_ar(input int n);
      ar_valid = 1'b1;
      ar_id    = id_q[n][lite_bus_pkg::ID_W-1:0];
      ar_addr  = addr_q[n][lite_bus_pkg::ADDR_W-1:0];
      do @(negedge clk); while (!ar_ready);
      @(posedge clk);
      #1;
      ar_valid = 1'b0;
   endtask

   task automatic test_write(input int n);
      int errs_before;
      errs_before = errors;
      issue_write(n);
      while (b_id_q.size() == 0) begin
         @(posedge clk);
         #1;
      end
      check_value(b_id_q.pop_front(), id_q[n], "B id");
      check_value(b_resp_q.pop_front(), OKAY, "B resp");
      check_value(b_id_q.size(), 0, "count of extra B responses");
      report_test($sformatf("write id %0d addr %h", id_q[n], addr_q[n][7:0]), errs_before);
   endtask

   task automatic test_read(input int n);
      int errs_before;
      errs_before = errors;
      issue_ar(n);
      while (r_id_q.size() == 0) begin
         @(posedge clk);
         #1;
      end
      check_value(r_id_q.pop_front(), id_q[n], "R id");
      check_value(r_data_q.pop_front(), exp_q[n], "R data");
      check_value(r_resp_q.pop_front(), OKAY, "R resp");
      report_test($sformatf("read id %0d addr %h", id_q[n], addr_q[n][7:0]), errs_before);
   endtask

   task automatic queue_read(input int n);
      if (pend_on[id_q[n][lite_bus_pkg::ID_W-1:0]]) begin
         $display("stimulus line %0d reuses an id that is still outstanding", n);
         errors++;
      end
      issue_ar(n);
      pend_exp[id_q[n][lite_bus_pkg::ID_W-1:0]] = exp_q[n];
      pend_on[id_q[n][lite_bus_pkg::ID_W-1:0]]  = 1'b1;
      pend_cnt++;
   endtask

   // responses of a pipelined group, matched by id in any order
   task automatic collect_reads();
      int                            errs_before;
      int                            count;
      logic [lite_bus_pkg::ID_W-1:0] id;
      errs_before = errors;
      count       = pend_cnt;
      while (r_id_q.size() < pend_cnt) begin
         @(posedge clk);
         #1;
      end
      for (int k = 0; k < count; k++) begin
         id = r_id_q.pop_front();
         if (!pend_on[id]) begin
            $display("read response with id %0d was not outstanding or came twice", id);
            errors++;
            void'(r_data_q.pop_front());
         end else begin
            check_value(r_data_q.pop_front(), pend_exp[id], $sformatf("R data id %0d", id));
            pend_on[id] = 1'b0;
         end
         check_value(r_resp_q.pop_front(), OKAY, "R resp");
      end
      pend_cnt = 0;
      check_value(r_id_q.size(), 0, "count of extra R responses");
      report_test($sformatf("%0d back-to-back reads", count), errs_before);
   endtask

   initial begin
      rstn     = 1'b0;
      aw_valid = 1'b0;
      aw_id    = '0;
      aw_addr  = '0;
      w_valid  = 1'b0;
      w_data   = '0;
      w_strb   = '0;
      ar_valid = 1'b0;
      ar_id    = '0;
      ar_addr  = '0;
      errors   = 0;
      tests    = 0;
      pend_cnt = 0;
      limit_cycles = 0;
      foreach (pend_on[k]) pend_on[k] = 1'b0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("could not open the stimulus file %s", STIM_FILE);
         $display("Regression failed");
         $finish;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
               nread = $sscanf(line, "%c %h %h %h %h %h", f_op, f_id, f_addr, f_data,
                               f_strb, f_exp);
               if (nread == 6) begin
                  op_q.push_back(f_op);
                  id_q.push_back(f_id);
                  addr_q.push_back(f_addr);
                  data_q.push_back(f_data);
                  strb_q.push_back(f_strb);
                  exp_q.push_back(f_exp);
               end else begin
                  $display("stimulus line could not be parsed: %s", line);
                  errors++;
               end
            end
         end
         $fclose(fd);
         limit_cycles = RESET_CYCLES + LINE_CYCLES * (op_q.size() + 1);

         repeat (RESET_CYCLES) @(posedge clk);
         #1;
         rstn = 1'b1;
         @(negedge clk);
         check_value(b_valid, 1'b0, "b_valid after reset");
         check_value(r_valid, 1'b0, "r_valid after reset");
         report_test("reset state", 0);
         @(posedge clk);
         #1;

         for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] != "P" && pend_cnt > 0) collect_reads();
            case (op_q[i])
               "W": test_write(i);
               "R": test_read(i);
               "P": queue_read(i);
               default: begin
                  $display("stimulus line %0d has an unknown opcode", i);
                  errors++;
               end
            endcase
         end
         if (pend_cnt > 0) collect_reads();
         repeat (4) @(posedge clk);
         check_value(b_id_q.size(), 0, "late B responses");
         check_value(r_id_q.size(), 0, "late R responses");

         $display("tests run %0d, checks failed %0d", tests, errors);
         if (errors == 0 && tests > 1)
            $display("Regression passed");
         else
            $display("Regression failed");
         $finish;
      end
   end

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout after %0d cycles, the DUT stopped completing transfers", limit_cycles);
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/lite_bus_pkg.sv
// bus widths, port count, target address map and response codes
// shared by the demultiplexer, the register targets and the top level
`default_nettype none

package lite_bus_pkg;

   localparam int ADDR_W = 8;               // byte address
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;      // one strobe per byte
   localparam int ID_W   = 2;

   localparam int PORTS  = 4;               // target ports on the demux
   localparam int SEL_W  = 2;               // port select width
   localparam int WORDS  = 16;              // words per register target

   // address map, entry p belongs to port p
   localparam logic [PORTS-1:0][ADDR_W-1:0] BASE = {
      8'hC0,
      8'h80,
      8'h40,
      8'h00
   };

   // a zero mask disables the port
   localparam logic [PORTS-1:0][ADDR_W-1:0] MASK = {
      8'h3F,
      8'h3F,
      8'h3F,
      8'h3F
   };

   localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

//--- verilog/lite_demux.sv
// NASTI-Lite address demultiplexer: decode, write lock, request fan-out
// and round-robin merge of the B and R returns
`timescale 1ns/1ps
`default_nettype none

module lite_demux (
   input  logic                                            clk,
   input  logic                                            rstn,
   // master side
   input  logic                                            aw_valid,
   output logic                                            aw_ready,
   input  logic [lite_bus_pkg::ID_W-1:0]                   aw_id,
   input  logic [lite_bus_pkg::ADDR_W-1:0]                 aw_addr,
   input  logic                                            w_valid,
   output logic                                            w_ready,
   input  logic [lite_bus_pkg::DATA_W-1:0]                 w_data,
   input  logic [lite_bus_pkg::STRB_W-1:0]                 w_strb,
   output logic                                            b_valid,
   input  logic                                            b_ready,
   output logic [lite_bus_pkg::ID_W-1:0]                   b_id,
   output logic [1:0]                                      b_resp,
   input  logic                                            ar_valid,
   output logic                                            ar_ready,
   input  logic [lite_bus_pkg::ID_W-1:0]                   ar_id,
   input  logic [lite_bus_pkg::ADDR_W-1:0]                 ar_addr,
   output logic                                            r_valid,
   input  logic                                            r_ready,
   output logic [lite_bus_pkg::ID_W-1:0]                   r_id,
   output logic [lite_bus_pkg::DATA_W-1:0]                 r_data,
   output logic [1:0]                                      r_resp,
   // target side, indexed by port
   output logic [lite_bus_pkg::PORTS-1:0]                  t_aw_valid,
   input  logic [lite_bus_pkg::PORTS-1:0]                  t_aw_ready,
   output logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ID_W-1:0]   t_aw_id,
   output logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ADDR_W-1:0] t_aw_addr,
   output logic [lite_bus_pkg::PORTS-1:0]                  t_w_valid,
   input  logic [lite_bus_pkg::PORTS-1:0]                  t_w_ready,
   output logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::DATA_W-1:0] t_w_data,
   output logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::STRB_W-1:0] t_w_strb,
   input  logic [lite_bus_pkg::PORTS-1:0]                  t_b_valid,
   output logic [lite_bus_pkg::PORTS-1:0]                  t_b_ready,
   input  logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ID_W-1:0]   t_b_id,
   input  logic [lite_bus_pkg::PORTS-1:0][1:0]             t_b_resp,
   output logic [lite_bus_pkg::PORTS-1:0]                  t_ar_valid,
   input  logic [lite_bus_pkg::PORTS-1:0]                  t_ar_ready,
   output logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ID_W-1:0]   t_ar_id,
   output logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ADDR_W-1:0] t_ar_addr,
   input  logic [lite_bus_pkg::PORTS-1:0]                  t_r_valid,
   output logic [lite_bus_pkg::PORTS-1:0]                  t_r_ready,
   input  logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ID_W-1:0]   t_r_id,
   input  logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::DATA_W-1:0] t_r_data,
   input  logic [lite_bus_pkg::PORTS-1:0][1:0]             t_r_resp
);

   // lowest enabled port whose base matches, port 0 when none does
   function automatic logic [lite_bus_pkg::SEL_W-1:0] port_match(
      input logic [lite_bus_pkg::ADDR_W-1:0] addr);
      logic [lite_bus_pkg::SEL_W-1:0] sel;
      sel = '0;
      for (int p = lite_bus_pkg::PORTS - 1; p >= 0; p--)
         if (lite_bus_pkg::MASK[p] != '0 &&
             (addr & ~lite_bus_pkg::MASK[p]) == lite_bus_pkg::BASE[p])
            sel = lite_bus_pkg::SEL_W'(p);
      return sel;
   endfunction

   function automatic logic [lite_bus_pkg::SEL_W-1:0] onehot_idx(
      input logic [lite_bus_pkg::PORTS-1:0] oh);
      logic [lite_bus_pkg::SEL_W-1:0] idx;
      idx = '0;
      for (int p = 0; p < lite_bus_pkg::PORTS; p++)
         if (oh[p]) idx = lite_bus_pkg::SEL_W'(p);
      return idx;
   endfunction

   logic                             lock;          // AW accepted, W still due
   logic [lite_bus_pkg::SEL_W-1:0]   locked_port;
   logic [lite_bus_pkg::SEL_W-1:0]   aw_sel;
   logic [lite_bus_pkg::SEL_W-1:0]   ar_sel;
   logic [lite_bus_pkg::PORTS-1:0]   port_en;
   logic [lite_bus_pkg::PORTS-1:0]   b_req, b_gnt;
   logic [lite_bus_pkg::PORTS-1:0]   r_req, r_gnt;
   logic [lite_bus_pkg::SEL_W-1:0]   b_sel, r_sel;

   assign aw_sel = lock ? locked_port : port_match(aw_addr);
   assign ar_sel = port_match(ar_addr);

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn)
         lock <= 1'b0;
      else if (aw_valid && aw_ready)
         lock <= 1'b1;
      else if (w_valid && w_ready)
         lock <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (aw_valid && aw_ready) locked_port <= aw_sel;
   end

   always_comb begin
      for (int p = 0; p < lite_bus_pkg::PORTS; p++) begin
         t_aw_id[p]    = aw_id;                 // fields go to every port
         t_aw_addr[p]  = aw_addr;
         t_w_data[p]   = w_data;
         t_w_strb[p]   = w_strb;
         t_ar_id[p]    = ar_id;
         t_ar_addr[p]  = ar_addr;
         t_aw_valid[p] = !lock && aw_sel == p && aw_valid;
         t_w_valid[p]  = lock && aw_sel == p && w_valid;
         t_ar_valid[p] = ar_sel == p && ar_valid;
         port_en[p]    = lite_bus_pkg::MASK[p] != '0;
      end
   end

   assign aw_ready = !lock && t_aw_ready[aw_sel];
   assign w_ready  = lock && t_w_ready[aw_sel];
   assign ar_ready = t_ar_ready[ar_sel];

   // B return
   assign b_req = t_b_valid & port_en;

   rr_arbiter #(.N(lite_bus_pkg::PORTS)) u_b_arb (
      .clk     (clk),
      .rstn    (rstn),
      .req     (b_req),
      .advance (b_valid && b_ready),
      .gnt     (b_gnt)
   );

   assign b_sel     = onehot_idx(b_gnt);
   assign b_valid   = |(b_req & b_gnt);
   assign b_id      = t_b_id[b_sel];
   assign b_resp    = t_b_resp[b_sel];
   assign t_b_ready = b_ready ? b_gnt : '0;

   // R return
   assign r_req = t_r_valid & port_en;

   rr_arbiter #(.N(lite_bus_pkg::PORTS)) u_r_arb (
      .clk     (clk),
      .rstn    (rstn),
      .req     (r_req),
      .advance (r_valid && r_ready),
      .gnt     (r_gnt)
   );

   assign r_sel     = onehot_idx(r_gnt);
   assign r_valid   = |(r_req & r_gnt);
   assign r_id      = t_r_id[r_sel];
   assign r_data    = t_r_data[r_sel];
   assign r_resp    = t_r_resp[r_sel];
   assign t_r_ready = r_ready ? r_gnt : '0;

endmodule

`default_nettype wire

//--- verilog/lite_reg_target.sv
// NASTI-Lite register target: 16 words with byte strobes,
// one held B response and one held R response
`timescale 1ns/1ps
`default_nettype none

module lite_reg_target (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              aw_valid,
   output logic                              aw_ready,
   input  logic [lite_bus_pkg::ID_W-1:0]     aw_id,
   input  logic [lite_bus_pkg::ADDR_W-1:0]   aw_addr,
   input  logic                              w_valid,
   output logic                              w_ready,
   input  logic [lite_bus_pkg::DATA_W-1:0]   w_data,
   input  logic [lite_bus_pkg::STRB_W-1:0]   w_strb,
   output logic                              b_valid,
   input  logic                              b_ready,
   output logic [lite_bus_pkg::ID_W-1:0]     b_id,
   output logic [1:0]                        b_resp,
   input  logic                              ar_valid,
   output logic                              ar_ready,
   input  logic [lite_bus_pkg::ID_W-1:0]     ar_id,
   input  logic [lite_bus_pkg::ADDR_W-1:0]   ar_addr,
   output logic                              r_valid,
   input  logic                              r_ready,
   output logic [lite_bus_pkg::ID_W-1:0]     r_id,
   output logic [lite_bus_pkg::DATA_W-1:0]   r_data,
   output logic [1:0]                        r_resp
);

   localparam int IDX_W = $clog2(lite_bus_pkg::WORDS);

   logic [lite_bus_pkg::DATA_W-1:0] mem [lite_bus_pkg::WORDS];
   logic                            aw_pending;    // address taken, data due
   logic [IDX_W-1:0]                w_idx;
   logic [lite_bus_pkg::ID_W-1:0]   w_id;
   logic [IDX_W-1:0]                r_idx;

   assign aw_ready = !aw_pending && !b_valid;  // one write at a time
   assign w_ready  = aw_pending;
   assign ar_ready = !r_valid;
   assign b_resp   = lite_bus_pkg::RESP_OKAY;
   assign r_resp   = lite_bus_pkg::RESP_OKAY;
   assign r_idx    = ar_addr[IDX_W+1:2];       // word index

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         aw_pending <= 1'b0;
         b_valid    <= 1'b0;
         r_valid    <= 1'b0;
         for (int i = 0; i < lite_bus_pkg::WORDS; i++)
            mem[i] <= '0;
      end else begin
         if (aw_valid && aw_ready)
            aw_pending <= 1'b1;
         else if (w_valid && w_ready)
            aw_pending <= 1'b0;

         if (w_valid && w_ready) begin
            b_valid <= 1'b1;
            for (int b = 0; b < lite_bus_pkg::STRB_W; b++)
               if (w_strb[b]) mem[w_idx][8*b +: 8] <= w_data[8*b +: 8];
         end else if (b_ready) begin
            b_valid <= 1'b0;
         end

         if (ar_valid && ar_ready)
            r_valid <= 1'b1;
         else if (r_ready)
            r_valid <= 1'b0;
      end
   end

   // saved address and response payload
   always_ff @(posedge clk) begin
      if (aw_valid && aw_ready) begin
         w_idx <= aw_addr[IDX_W+1:2];
         w_id  <= aw_id;
      end
      if (w_valid && w_ready) b_id <= w_id;
      if (ar_valid && ar_ready) begin
         r_id   <= ar_id;
         r_data <= mem[r_idx];
      end
   end

endmodule

`default_nettype wire

//--- verilog/lite_subsystem.sv
// top level: NASTI-Lite demultiplexer feeding four register targets
`timescale 1ns/1ps
`default_nettype none

module lite_subsystem (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              aw_valid,
   output logic                              aw_ready,
   input  logic [lite_bus_pkg::ID_W-1:0]     aw_id,
   input  logic [lite_bus_pkg::ADDR_W-1:0]   aw_addr,
   input  logic                              w_valid,
   output logic                              w_ready,
   input  logic [lite_bus_pkg::DATA_W-1:0]   w_data,
   input  logic [lite_bus_pkg::STRB_W-1:0]   w_strb,
   output logic                              b_valid,
   input  logic                              b_ready,
   output logic [lite_bus_pkg::ID_W-1:0]     b_id,
   output logic [1:0]                        b_resp,
   input  logic                              ar_valid,
   output logic                              ar_ready,
   input  logic [lite_bus_pkg::ID_W-1:0]     ar_id,
   input  logic [lite_bus_pkg::ADDR_W-1:0]   ar_addr,
   output logic                              r_valid,
   input  logic                              r_ready,
   output logic [lite_bus_pkg::ID_W-1:0]     r_id,
   output logic [lite_bus_pkg::DATA_W-1:0]   r_data,
   output logic [1:0]                        r_resp
);

   logic [lite_bus_pkg::PORTS-1:0]                           t_aw_valid, t_aw_ready;
   logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ID_W-1:0]   t_aw_id;
   logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ADDR_W-1:0] t_aw_addr;
   logic [lite_bus_pkg::PORTS-1:0]                           t_w_valid, t_w_ready;
   logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::DATA_W-1:0] t_w_data;
   logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::STRB_W-1:0] t_w_strb;
   logic [lite_bus_pkg::PORTS-1:0]                           t_b_valid, t_b_ready;
   logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ID_W-1:0]   t_b_id;
   logic [lite_bus_pkg::PORTS-1:0][1:0]                      t_b_resp;
   logic [lite_bus_pkg::PORTS-1:0]                           t_ar_valid, t_ar_ready;
   logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ID_W-1:0]   t_ar_id;
   logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ADDR_W-1:0] t_ar_addr;
   logic [lite_bus_pkg::PORTS-1:0]                           t_r_valid, t_r_ready;
   logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::ID_W-1:0]   t_r_id;
   logic [lite_bus_pkg::PORTS-1:0][lite_bus_pkg::DATA_W-1:0] t_r_data;
   logic [lite_bus_pkg::PORTS-1:0][1:0]                      t_r_resp;

   lite_demux u_demux (.*);   // master ports and t_* vectors share names

   // one register bank per demux port
   for (genvar i = 0; i < lite_bus_pkg::PORTS; i++) begin : g_tgt
      lite_reg_target u_tgt (
         .clk      (clk),
         .rstn     (rstn),
         .aw_valid (t_aw_valid[i]),
         .aw_ready (t_aw_ready[i]),
         .aw_id    (t_aw_id[i]),
         .aw_addr  (t_aw_addr[i]),
         .w_valid  (t_w_valid[i]),
         .w_ready  (t_w_ready[i]),
         .w_data   (t_w_data[i]),
         .w_strb   (t_w_strb[i]),
         .b_valid  (t_b_valid[i]),
         .b_ready  (t_b_ready[i]),
         .b_id     (t_b_id[i]),
         .b_resp   (t_b_resp[i]),
         .ar_valid (t_ar_valid[i]),
         .ar_ready (t_ar_ready[i]),
         .ar_id    (t_ar_id[i]),
         .ar_addr  (t_ar_addr[i]),
         .r_valid  (t_r_valid[i]),
         .r_ready  (t_r_ready[i]),
         .r_id     (t_r_id[i]),
         .r_data   (t_r_data[i]),
         .r_resp   (t_r_resp[i])
      );
   end

endmodule

`default_nettype wire

//--- verilog/rr_arbiter.sv
// round-robin arbiter with one-hot grant, held until the granted transfer
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
   parameter int N = 4
) (
   input  logic         clk,
   input  logic         rstn,
   input  logic [N-1:0] req,
   input  logic         advance,   // transfer on the arbitrated channel
   output logic [N-1:0] gnt
);

   localparam int PW = (N > 1) ? $clog2(N) : 1;

   logic [PW-1:0] ptr;               // highest priority port
   logic [PW-1:0] ptr_nxt;
   logic [N-1:0]  hold;              // grant kept while its response waits
   logic [N-1:0]  pick;

   // first requester at or after the pointer
   always_comb begin
      int   idx;
      logic found;
      pick  = '0;
      found = 1'b0;
      for (int i = 0; i < N; i++) begin
         idx = (int'(ptr) + i) % N;
         if (!found && req[idx]) begin
            pick[idx] = 1'b1;
            found     = 1'b1;
         end
      end
   end

   assign gnt = |(hold & req) ? hold : pick;   // a waiting response stays selected

   always_comb begin
      ptr_nxt = ptr;
      for (int i = 0; i < N; i++)
         if (gnt[i]) ptr_nxt = PW'((i + 1) % N);   // move past the winner
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         ptr  <= '0;
         hold <= '0;
      end else if (advance && |gnt) begin
         ptr  <= ptr_nxt;
         hold <= '0;
      end else begin
         hold <= gnt;
      end
   end

endmodule

`default_nettype wire
